// File: include/vga_consts.svh
// fixed 640x480 at 60 Hz on an 800x525 raster; two pixels per memory word, so FRAME_WORDS must stay half the visible area
`ifndef VGA_CONSTS_SVH
`define VGA_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// horizontal timing, in pixel clocks

`define VGA_H_ACTIVE 640    // visible pixels per line
`define VGA_H_SYNC_ON 656   // hsync goes low here
`define VGA_H_SYNC_OFF 752  // and back high here
`define VGA_H_TOTAL 800

////////////////////////////////////////////////////////////////////////////
// vertical timing, in lines

`define VGA_V_ACTIVE 480
`define VGA_V_SYNC_ON 490   // vsync low for two lines
`define VGA_V_SYNC_OFF 492
`define VGA_V_TOTAL 525

// position counter widths
`define HCOUNT_W 10
`define VCOUNT_W 10

////////////////////////////////////////////////////////////////////////////
// frame memory

`define FRAME_WORDS 153600  // 640 * 480 / 2
`define MEM_ADDR_W 18
`define FETCH_DEPTH 8       // fifo depth and number of read credits

`endif

// File: hdl/vga_pkg.sv
// types shared by the scan-out blocks; field widths follow the consts header and pixels are 6-bit ycbcr
`default_nettype none

`include "vga_consts.svh"

package vga_pkg;

	// one display pixel, only luma is drawn
	typedef struct packed {
		logic [5:0] luma;
		logic [5:0] cb;
		logic [5:0] cr;
	} pixel_t;

	// memory word, upper half goes out first
	typedef struct packed {
		pixel_t first;
		pixel_t second;
	} pixel_word_t;

	typedef struct packed {
		logic [`HCOUNT_W-1:0] hcount;
		logic [`VCOUNT_W-1:0] vcount;
		logic hsync_n;
		logic vsync_n;
		logic blank;  // high outside the visible area
	} raster_t;

	typedef struct packed {
		logic valid;
		logic [`MEM_ADDR_W-1:0] addr;  // word address
	} mem_req_t;

	typedef struct packed {
		logic valid;
		pixel_word_t data;
	} mem_rsp_t;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
		logic hsync_n;
		logic vsync_n;
		logic blank_n;
	} vga_out_t;

endpackage

`default_nettype wire

// File: hdl/raster_timing.sv
// free-running 800x525 raster, starts at the top of vertical blank after reset; no frame restart input
`default_nettype none

`include "vga_consts.svh"

module raster_timing (
	input logic vclock,
	input logic reset,
	output vga_pkg::raster_t raster
);
	import vga_pkg::*;

	raster_t next_raster;
	logic h_last;
	logic v_last;

	assign h_last = (raster.hcount == `VGA_H_TOTAL - 1);
	assign v_last = (raster.vcount == `VGA_V_TOTAL - 1);

	////////////////////////////////////////////////////////////////////////////
	// next position, then flags decoded from that same position

	always_comb begin
		next_raster = raster;
		if (h_last) begin
			next_raster.hcount = '0;
			if (v_last) begin
				next_raster.vcount = '0;
			end else begin
				next_raster.vcount = raster.vcount + 1'b1;
			end
		end else begin
			next_raster.hcount = raster.hcount + 1'b1;
		end

		// sync pulses are active low
		next_raster.hsync_n = !((next_raster.hcount >= `VGA_H_SYNC_ON) &&
			(next_raster.hcount < `VGA_H_SYNC_OFF));
		next_raster.vsync_n = !((next_raster.vcount >= `VGA_V_SYNC_ON) &&
			(next_raster.vcount < `VGA_V_SYNC_OFF));
		next_raster.blank = (next_raster.hcount >= `VGA_H_ACTIVE) ||
			(next_raster.vcount >= `VGA_V_ACTIVE);
	end

	////////////////////////////////////////////////////////////////////////////
	// raster register

	always_ff @(posedge vclock) begin
		if (reset) begin
			// top of vertical blank, leaves 45 lines to prefetch
			raster.hcount <= '0;
			raster.vcount <= `VCOUNT_W'(`VGA_V_ACTIVE);
			raster.hsync_n <= 1'b1;
			raster.vsync_n <= 1'b1;
			raster.blank <= 1'b1;
		end else begin
			raster <= next_raster;
		end
	end

endmodule

`default_nettype wire

// File: hdl/pixel_word_fifo.sv
// DEPTH must be a power of two and at least 2; no full flag, the writer must never push into a full FIFO
`default_nettype none

module pixel_word_fifo #(
	parameter int DEPTH = 8
) (
	input logic vclock,
	input logic reset,
	input logic push,
	input vga_pkg::pixel_word_t push_word,
	input logic pop,
	output vga_pkg::pixel_word_t head_word,
	output logic not_empty
);
	import vga_pkg::*;

	localparam int PTR_W = $clog2(DEPTH);

	pixel_word_t storage [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;  // one extra bit so DEPTH fits

	always_ff @(posedge vclock) begin
		if (push) begin
			storage[wr_ptr] <= push_word;
		end
	end

	always_ff @(posedge vclock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) wr_ptr <= wr_ptr + 1'b1;  // pointers wrap on their own
			if (pop) rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign head_word = storage[rd_ptr];  // valid only while not_empty
	assign not_empty = (count != '0);

endmodule

`default_nettype wire

// File: hdl/pixel_fetcher.sv
// memory must take a request every cycle valid is high and answer each one once, in order, one cycle or more later
`default_nettype none

`include "vga_consts.svh"

module pixel_fetcher (
	input logic vclock,
	input logic reset,
	output vga_pkg::mem_req_t mem_req,
	input vga_pkg::mem_rsp_t mem_rsp,
	output vga_pkg::pixel_word_t head_word,
	output logic word_avail,
	input logic word_pop
);

	localparam int CREDIT_W = $clog2(`FETCH_DEPTH + 1);

	logic [CREDIT_W-1:0] credits;  // requests we may still issue
	logic [`MEM_ADDR_W-1:0] next_addr;
	logic issue;
	logic req_valid;
	logic [`MEM_ADDR_W-1:0] req_addr;

	// one request per cycle while any credit is left
	assign issue = (credits != '0);

	////////////////////////////////////////////////////////////////////////////
	// credits and address

	always_ff @(posedge vclock) begin
		if (reset) begin
			credits <= CREDIT_W'(`FETCH_DEPTH);
			next_addr <= '0;
			req_valid <= 1'b0;
		end else begin
			case ({issue, word_pop})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;  // none, or spent and returned together
			endcase

			if (issue) begin
				if (next_addr == `FRAME_WORDS - 1) begin
					next_addr <= '0;  // back to the top of the frame
				end else begin
					next_addr <= next_addr + 1'b1;
				end
			end

			req_valid <= issue;
		end
	end

	always_ff @(posedge vclock) begin
		req_addr <= next_addr;
	end

	assign mem_req.valid = req_valid;
	assign mem_req.addr = req_addr;

	////////////////////////////////////////////////////////////////////////////
	// response buffer

	// credits keep the fifo from overflowing
	pixel_word_fifo #(
		.DEPTH(`FETCH_DEPTH)
	) i_fifo (
		.vclock(vclock),
		.reset(reset),
		.push(mem_rsp.valid),
		.push_word(mem_rsp.data),
		.pop(word_pop),
		.head_word(head_word),
		.not_empty(word_avail)
	);

endmodule

`default_nettype wire

// File: hdl/pixel_serializer.sv
// grey output from luma only; underflow is sticky until reset and the pixel order is not realigned after it
`default_nettype none

module pixel_serializer (
	input logic vclock,
	input logic reset,
	input vga_pkg::raster_t raster,
	input vga_pkg::pixel_word_t head_word,
	input logic word_avail,
	output logic word_pop,
	output vga_pkg::vga_out_t vga_out,
	output logic underflow
);
	import vga_pkg::*;

	pixel_t pixel;
	logic visible;
	logic starved;
	logic [7:0] grey;

	assign visible = !raster.blank;
	assign starved = visible && !word_avail;

	// even column takes the upper half
	assign pixel = raster.hcount[0] ? head_word.second : head_word.first;
	assign grey = (visible && word_avail) ? {pixel.luma, 2'b00} : 8'd0;

	////////////////////////////////////////////////////////////////////////////
	// output registers

	always_ff @(posedge vclock) begin
		if (reset) begin
			vga_out.red <= '0;
			vga_out.green <= '0;
			vga_out.blue <= '0;
			vga_out.hsync_n <= 1'b1;
			vga_out.vsync_n <= 1'b1;
			vga_out.blank_n <= 1'b0;
			word_pop <= 1'b0;
			underflow <= 1'b0;
		end else begin
			vga_out.red <= grey;
			vga_out.green <= grey;
			vga_out.blue <= grey;
			vga_out.hsync_n <= raster.hsync_n;
			vga_out.vsync_n <= raster.vsync_n;
			vga_out.blank_n <= visible;

			// pop lands in the odd column cycle, so the word leaves
			// the head right after its second half was read
			word_pop <= visible && word_avail && !raster.hcount[0];

			if (starved) begin
				underflow <= 1'b1;  // sticky
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/vga_scanout.sv
// single vclock domain; the frame memory is external and must follow the credit read protocol of the fetcher
`default_nettype none

module vga_scanout (
	input logic vclock,
	input logic reset,
	output vga_pkg::mem_req_t mem_req,
	input vga_pkg::mem_rsp_t mem_rsp,
	output vga_pkg::vga_out_t vga_out,
	output logic underflow
);
	import vga_pkg::*;

	raster_t raster;
	pixel_word_t head_word;
	logic word_avail;
	logic word_pop;

	raster_timing i_timing (
		.vclock(vclock),
		.reset(reset),
		.raster(raster)
	);

	pixel_fetcher i_fetcher (
		.vclock(vclock),
		.reset(reset),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp),
		.head_word(head_word),
		.word_avail(word_avail),
		.word_pop(word_pop)
	);

	pixel_serializer i_serializer (
		.vclock(vclock),
		.reset(reset),
		.raster(raster),
		.head_word(head_word),
		.word_avail(word_avail),
		.word_pop(word_pop),
		.vga_out(vga_out),
		.underflow(underflow)
	);

endmodule

`default_nettype wire

// File: verif/tb_vga_scanout.sv
// memory content is a fixed mix of address bits; pixel data is only checked until the forced underflow
`default_nettype none

`include "vga_consts.svh"

module tb_vga_scanout;
	import vga_pkg::*;

	localparam int FRAME_CYCLES = `VGA_H_TOTAL * `VGA_V_TOTAL;
	localparam int COLOUR_NONE = 0;
	localparam int COLOUR_FULL = 1;
	localparam int COLOUR_BLACK = 2;  // black once the buffered words run out
	localparam int UF_LOW = 0;
	localparam int UF_ANY = 1;
	localparam int UF_HIGH = 2;

	logic vclock;
	logic reset;
	mem_req_t mem_req;
	mem_rsp_t mem_rsp;
	vga_out_t vga_out;
	logic underflow;

	logic [`MEM_ADDR_W-1:0] pending_addr [$];
	longint pending_due [$];  // edge on which each answer may go out
	longint edge_count = 0;
	logic [15:0] lfsr_state = 16'd12224;
	logic random_latency = 1'b0;
	logic mem_silent = 1'b0;

	logic tracking = 1'b0;
	int pos_h = 0;
	int pos_v = `VGA_V_ACTIVE;
	int colour_mode = COLOUR_FULL;
	int underflow_mode = UF_LOW;
	longint req_count = 0;
	longint shown_count = 0;

	vga_scanout i_dut (
		.vclock(vclock),
		.reset(reset),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp),
		.vga_out(vga_out),
		.underflow(underflow)
	);

	initial begin
		vclock = 1'b0;
		forever #4 vclock = ~vclock;
	end

	////////////////////////////////////////////////////////////////////////////
	// reference model

	function automatic pixel_word_t word_data(input logic [`MEM_ADDR_W-1:0] addr);
		pixel_word_t w;
		w.first.luma = addr[5:0] ^ addr[17:12];
		w.first.cb = addr[11:6];
		w.first.cr = addr[5:0] ^ 6'h2a;
		w.second.luma = ~addr[5:0] ^ addr[11:6];
		w.second.cb = addr[17:12];
		w.second.cr = addr[11:6] ^ 6'h15;
		return w;
	endfunction

	function automatic vga_out_t expected_out(input int h, input int v);
		vga_out_t exp;
		pixel_word_t w;
		logic [5:0] luma;
		exp = '0;
		exp.hsync_n = !(h >= `VGA_H_SYNC_ON && h < `VGA_H_SYNC_OFF);
		exp.vsync_n = !(v >= `VGA_V_SYNC_ON && v < `VGA_V_SYNC_OFF);
		exp.blank_n = (h < `VGA_H_ACTIVE) && (v < `VGA_V_ACTIVE);
		if (exp.blank_n) begin
			w = word_data(`MEM_ADDR_W'((v * `VGA_H_ACTIVE + h) / 2));
			luma = (h % 2 == 1) ? w.second.luma : w.first.luma;  // odd column is lower half
			exp.red = {luma, 2'b00};
			exp.green = {luma, 2'b00};
			exp.blue = {luma, 2'b00};
		end
		return exp;
	endfunction

	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 16'hb400;
		end else begin
			return state >> 1;
		end
	endfunction

	// three bits per draw, 1 to 6 cycles
	function automatic int draw_latency();
		int r;
		r = 0;
		repeat (3) begin
			r = (r << 1) | int'(lfsr_state[0]);
			lfsr_state = lfsr_next(lfsr_state);
		end
		return (r % 6) + 1;
	endfunction

	task automatic report_failure(input string reason);
		$display("%s", reason);
		$display("Test failures found");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_equal(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected) begin
			report_failure($sformatf("[ERROR] %s at h=%0d v=%0d: got 0x%0h, expected 0x%0h",
				name, pos_h, pos_v, actual, expected));
		end
	endtask

	task automatic wait_for_position(input int h, input int v);
		int cycles;
		bit reached;
		cycles = 0;
		reached = 1'b0;
		while (!reached) begin
			@(posedge vclock);
			cycles++;
			if (tracking && pos_h == h && pos_v == v) begin
				reached = 1'b1;
			end else if (cycles > FRAME_CYCLES + 100) begin
				report_failure($sformatf("timed out waiting for position h=%0d v=%0d", h, v));
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// frame memory stand-in

	always @(negedge vclock) begin
		if (edge_count > 0 && mem_req.valid === 1'b1) begin
			pending_addr.push_back(mem_req.addr);
			pending_due.push_back(edge_count + (random_latency ? draw_latency() : 1));
		end
	end

	always @(posedge vclock) begin
		edge_count = edge_count + 1;
		// answers stay in order even when a later one is due earlier
		if (!mem_silent && pending_addr.size() != 0 && pending_due[0] <= edge_count) begin
			mem_rsp <= {1'b1, word_data(pending_addr.pop_front())};
			void'(pending_due.pop_front());
		end else begin
			mem_rsp <= '0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// comparison, one tracked position per cycle

	always @(negedge vclock) begin
		vga_out_t exp;
		if (edge_count > 0 && (reset || !tracking)) begin
			check_equal("mem_req.valid", mem_req.valid, 1'b0);
			check_equal("vga_out.hsync_n", vga_out.hsync_n, 1'b1);
			check_equal("vga_out.vsync_n", vga_out.vsync_n, 1'b1);
			check_equal("vga_out.blank_n", vga_out.blank_n, 1'b0);
			check_equal("vga_out.colour", {vga_out.red, vga_out.green, vga_out.blue}, 24'h0);
			check_equal("underflow", underflow, 1'b0);
			if (!reset) begin
				tracking = 1'b1;  // next cycle shows h 0, v 480
			end
		end else if (tracking) begin
			exp = expected_out(pos_h, pos_v);
			if (mem_req.valid) begin
				// word addresses run in order and wrap at the frame end
				check_equal("mem_req.addr", mem_req.addr, req_count % `FRAME_WORDS);
			end
			req_count += mem_req.valid;
			shown_count += vga_out.blank_n;
			check_equal("vga_out.hsync_n", vga_out.hsync_n, exp.hsync_n);
			check_equal("vga_out.vsync_n", vga_out.vsync_n, exp.vsync_n);
			check_equal("vga_out.blank_n", vga_out.blank_n, exp.blank_n);
			if (!exp.blank_n || colour_mode == COLOUR_FULL) begin
				check_equal("vga_out.red", vga_out.red, exp.red);
				check_equal("vga_out.green", vga_out.green, exp.green);
				check_equal("vga_out.blue", vga_out.blue, exp.blue);
			end else if (colour_mode == COLOUR_BLACK && pos_h >= 2 * `FETCH_DEPTH) begin
				check_equal("vga_out.colour", {vga_out.red, vga_out.green, vga_out.blue}, 24'h0);
			end
			if (underflow_mode != UF_ANY) begin
				check_equal("underflow", underflow, underflow_mode == UF_HIGH);
			end
			if (req_count - shown_count / 2 > `FETCH_DEPTH) begin
				report_failure("more reads outstanding than the fetch depth allows");
			end
			pos_h = (pos_h == `VGA_H_TOTAL - 1) ? 0 : pos_h + 1;
			if (pos_h == 0) begin
				pos_v = (pos_v == `VGA_V_TOTAL - 1) ? 0 : pos_v + 1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// phases

	initial begin
		reset = 1'b1;
		mem_rsp = '0;
		repeat (10) @(posedge vclock);
		reset <= 1'b0;

		// latency 1, two frames across the address wrap
		wait_for_position(0, 0);
		wait_for_position(0, `VGA_V_ACTIVE);
		wait_for_position(0, 0);
		wait_for_position(0, `VGA_V_ACTIVE);

		random_latency <= 1'b1;
		wait_for_position(0, 0);
		wait_for_position(`VGA_H_ACTIVE, 120);

		// memory silent for all of line 121
		mem_silent <= 1'b1;
		colour_mode <= COLOUR_BLACK;
		underflow_mode <= UF_ANY;
		wait_for_position(`VGA_H_ACTIVE, 121);
		mem_silent <= 1'b0;
		colour_mode <= COLOUR_NONE;  // order stays shifted from here
		underflow_mode <= UF_HIGH;
		wait_for_position(0, 124);

		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
hdl/vga_pkg.sv
hdl/raster_timing.sv
hdl/pixel_word_fifo.sv
hdl/pixel_fetcher.sv
hdl/pixel_serializer.sv
hdl/vga_scanout.sv
verif/tb_vga_scanout.sv
